// File: design/alu_unit.sv
/*
 * Single-cycle ALU pipe
 * Registered result that holds while writeback refuses it
 */
module alu_unit
  import blimp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // From decode
  input  logic     alu_val,
  input  alu_op_t  alu_op,
  input  word_t    alu_a,
  input  word_t    alu_b,
  input  addr_t    alu_pc,
  input  reg_idx_t alu_waddr,
  output logic     alu_rdy,
  // To writeback
  output logic     x_val,
  output addr_t    x_pc,
  output reg_idx_t x_waddr,
  output word_t    x_wdata,
  input  logic     x_rdy
);

  word_t      result;
  logic [4:0] shamt;

  assign shamt = alu_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:   result = alu_a + alu_b;
      ALU_SUB:   result = alu_a - alu_b;
      ALU_AND:   result = alu_a & alu_b;
      ALU_OR:    result = alu_a | alu_b;
      ALU_XOR:   result = alu_a ^ alu_b;
      ALU_SLT:   result = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:  result = {31'b0, alu_a < alu_b};
      ALU_SLL:   result = alu_a << shamt;
      ALU_SRL:   result = alu_a >> shamt;
      ALU_SRA:   result = word_t'($signed(alu_a) >>> shamt);
      ALU_LUI:   result = alu_b;
      ALU_AUIPC: result = alu_pc + alu_b;
      default:   result = alu_a + alu_b;
    endcase
  end

  // Free when empty or the held result leaves this cycle
  assign alu_rdy = !x_val || x_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      x_val <= 1'b0;
    end else if (alu_val && alu_rdy) begin
      x_val <= 1'b1;
    end else if (x_rdy) begin
      x_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_val && alu_rdy) begin
      x_pc    <= alu_pc;
      x_waddr <= alu_waddr;
      x_wdata <= result;
    end
  end

endmodule

// File: design/blimp_core.sv
/*
 * Blimp demo core
 * In-order issue of RV32I ALU ops and MUL, out-of-order completion
 * across an ALU pipe and an iterative multiplier
 */
module blimp_core
  import blimp_pkg::*;
#(
  parameter int p_max_in_flight = 2,
  parameter int p_num_cycles    = 16
) (
  input  logic     clk,
  input  logic     reset,
  // Instruction memory
  output logic     imem_req_val,
  output addr_t    imem_req_addr,
  input  logic     imem_resp_val,
  input  word_t    imem_resp_data,
  // Instruction trace
  output logic     trace_val,
  output addr_t    trace_pc,
  output reg_idx_t trace_waddr,
  output word_t    trace_wdata,
  output logic     trace_wen
);

  // --------------------
  // Stage wires
  // --------------------

  // Fetch to decode
  logic     f_val;
  addr_t    f_pc;
  word_t    f_inst;
  logic     f_rdy;

  // Decode to ALU
  logic     alu_val;
  alu_op_t  alu_op;
  word_t    alu_a;
  word_t    alu_b;
  addr_t    alu_pc;
  reg_idx_t alu_waddr;
  logic     alu_rdy;

  // Decode to multiplier
  logic     mul_val;
  word_t    mul_a;
  word_t    mul_b;
  addr_t    mul_pc;
  reg_idx_t mul_waddr;
  logic     mul_rdy;

  // Pipes to writeback
  logic     alu_x_val;
  addr_t    alu_x_pc;
  reg_idx_t alu_x_waddr;
  word_t    alu_x_wdata;
  logic     alu_x_rdy;
  logic     mul_x_val;
  addr_t    mul_x_pc;
  reg_idx_t mul_x_waddr;
  word_t    mul_x_wdata;
  logic     mul_x_rdy;

  // Commit back to decode
  logic     cmt_val;
  reg_idx_t cmt_waddr;
  word_t    cmt_wdata;

  // --------------------
  // Units
  // --------------------

  fetch_unit #(
    .p_max_in_flight (p_max_in_flight)
  ) fu (.*);

  decode_issue_unit diu (.*);

  alu_unit alu_xu (
    .x_val   (alu_x_val),
    .x_pc    (alu_x_pc),
    .x_waddr (alu_x_waddr),
    .x_wdata (alu_x_wdata),
    .x_rdy   (alu_x_rdy),
    .*
  );

  iterative_multiplier #(
    .p_num_cycles (p_num_cycles)
  ) mul_xu (
    .x_val   (mul_x_val),
    .x_pc    (mul_x_pc),
    .x_waddr (mul_x_waddr),
    .x_wdata (mul_x_wdata),
    .x_rdy   (mul_x_rdy),
    .*
  );

  writeback_commit_unit wcu (.*);

endmodule

// File: design/blimp_pkg.sv
/*
 * Blimp core shared definitions
 * Data and address widths, RV32 opcodes, ALU operation codes
 * and the multiplier FSM states
 */
package blimp_pkg;

  // --------------------
  // Widths
  // --------------------

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  alu_op_t;

  // --------------------
  // RV32 opcodes
  // --------------------

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // --------------------
  // ALU operations
  // --------------------

  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_AND   = 4'd2;
  localparam alu_op_t ALU_OR    = 4'd3;
  localparam alu_op_t ALU_XOR   = 4'd4;
  localparam alu_op_t ALU_SLT   = 4'd5;
  localparam alu_op_t ALU_SLTU  = 4'd6;
  localparam alu_op_t ALU_SLL   = 4'd7;
  localparam alu_op_t ALU_SRL   = 4'd8;
  localparam alu_op_t ALU_SRA   = 4'd9;
  localparam alu_op_t ALU_LUI   = 4'd10;
  localparam alu_op_t ALU_AUIPC = 4'd11;

  // Iterative multiplier FSM
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mul_state_t;

endpackage

// File: design/decode_issue_unit.sv
/*
 * Decode and issue unit
 * Decodes RV32I ALU ops and MUL, reads the register file and issues
 * to the ALU or multiplier pipe once the scoreboard shows no hazard
 */
module decode_issue_unit
  import blimp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // From fetch
  input  logic     f_val,
  input  addr_t    f_pc,
  input  word_t    f_inst,
  output logic     f_rdy,
  // ALU issue
  output logic     alu_val,
  output alu_op_t  alu_op,
  output word_t    alu_a,
  output word_t    alu_b,
  output addr_t    alu_pc,
  output reg_idx_t alu_waddr,
  input  logic     alu_rdy,
  // Multiplier issue
  output logic     mul_val,
  output word_t    mul_a,
  output word_t    mul_b,
  output addr_t    mul_pc,
  output reg_idx_t mul_waddr,
  input  logic     mul_rdy,
  // Commit write
  input  logic     cmt_val,
  input  reg_idx_t cmt_waddr,
  input  word_t    cmt_wdata
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  reg_idx_t    rd;
  word_t       imm_i;
  word_t       imm_u;
  word_t       rs1_val;
  word_t       rs2_val;
  word_t       opnd_b;
  alu_op_t     dec_op;
  logic        is_mul;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        hazard;
  logic        issue;
  logic [31:0] pending;
  word_t       rf [32];

  // funct3 to ALU op, SUB only exists in the register form
  function automatic alu_op_t funct_to_op(input logic [2:0] f3, input logic alt,
                                          input logic reg_op);
    alu_op_t op;
    case (f3)
      3'b000:  op = (reg_op && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // --------------------
  // Decode
  // --------------------

  assign opcode = f_inst[6:0];
  assign rd     = f_inst[11:7];
  assign funct3 = f_inst[14:12];
  assign rs1    = f_inst[19:15];
  assign rs2    = f_inst[24:20];
  assign funct7 = f_inst[31:25];

  assign imm_i  = {{20{f_inst[31]}}, f_inst[31:20]};
  assign imm_u  = {f_inst[31:12], 12'b0};
  assign is_mul = (opcode == OPC_OP) && (funct7 == 7'b0000001);

  always_comb begin
    dec_op   = ALU_ADD;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    opnd_b   = imm_u;
    case (opcode)
      OPC_OP: begin
        dec_op   = funct_to_op(funct3, funct7[5], 1'b1);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        opnd_b   = rs2_val;
      end
      OPC_OP_IMM: begin
        // Bit 30 only matters for SRAI
        dec_op   = funct_to_op(funct3, funct7[5], 1'b0);
        uses_rs1 = 1'b1;
        opnd_b   = imm_i;
      end
      OPC_LUI:   dec_op = ALU_LUI;
      OPC_AUIPC: dec_op = ALU_AUIPC;
      default:   dec_op = ALU_ADD;
    endcase
  end

  // x0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  // RAW on either source, WAW on the destination
  assign hazard = (uses_rs1 && pending[rs1]) || (uses_rs2 && pending[rs2]) || pending[rd];

  // --------------------
  // Issue
  // --------------------

  assign f_rdy   = !hazard && (is_mul ? mul_rdy : alu_rdy);
  assign issue   = f_val && f_rdy;
  assign alu_val = f_val && !hazard && !is_mul;
  assign mul_val = f_val && !hazard && is_mul;

  assign alu_op    = dec_op;
  assign alu_a     = rs1_val;
  assign alu_b     = opnd_b;
  assign alu_pc    = f_pc;
  assign alu_waddr = rd;

  assign mul_a     = rs1_val;
  assign mul_b     = rs2_val;
  assign mul_pc    = f_pc;
  assign mul_waddr = rd;

  // Register file write from commit
  always_ff @(posedge clk) begin
    if (cmt_val && (cmt_waddr != '0)) begin
      rf[cmt_waddr] <= cmt_wdata;
    end
  end

  // Scoreboard, one pending bit per register
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      if (cmt_val) begin
        pending[cmt_waddr] <= 1'b0;
      end
      if (issue && (rd != '0)) begin
        pending[rd] <= 1'b1;
      end
    end
  end

endmodule

// File: design/fetch_unit.sv
/*
 * Fetch unit
 * Issues sequential instruction requests and buffers the responses
 * in a small FIFO until decode takes them
 */
module fetch_unit
  import blimp_pkg::*;
#(
  parameter int p_max_in_flight = 2
) (
  input  logic  clk,
  input  logic  reset,
  // Instruction memory
  output logic  imem_req_val,
  output addr_t imem_req_addr,
  input  logic  imem_resp_val,
  input  word_t imem_resp_data,
  // To decode
  output logic  f_val,
  output addr_t f_pc,
  output word_t f_inst,
  input  logic  f_rdy
);

  localparam int p_ptr_bits = (p_max_in_flight > 1) ? $clog2(p_max_in_flight) : 1;
  localparam int p_cnt_bits = $clog2(p_max_in_flight + 1);

  logic                  fetch_en;
  addr_t                 resp_pc;
  logic [p_cnt_bits-1:0] inflight;
  logic [p_cnt_bits-1:0] count;
  logic [p_ptr_bits-1:0] wr_ptr;
  logic [p_ptr_bits-1:0] rd_ptr;
  logic                  deq;
  addr_t                 pc_buf [p_max_in_flight];
  word_t                 inst_buf [p_max_in_flight];

  // Only ask for what the FIFO can still take
  assign imem_req_val = fetch_en && ((int'(inflight) + int'(count)) < p_max_in_flight);

  assign f_val  = (count != '0);
  assign f_pc   = pc_buf[rd_ptr];
  assign f_inst = inst_buf[rd_ptr];
  assign deq    = f_val && f_rdy;

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_en      <= 1'b0;
      imem_req_addr <= '0;
      resp_pc       <= '0;
      inflight      <= '0;
      count         <= '0;
      wr_ptr        <= '0;
      rd_ptr        <= '0;
    end else begin
      // First request one cycle after reset
      fetch_en <= 1'b1;
      if (imem_req_val) begin
        imem_req_addr <= imem_req_addr + 32'd4;
      end
      // Responses come back in order, so their pc just counts up
      if (imem_resp_val) begin
        resp_pc <= resp_pc + 32'd4;
        wr_ptr  <= (wr_ptr == p_ptr_bits'(p_max_in_flight - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == p_ptr_bits'(p_max_in_flight - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({imem_req_val, imem_resp_val})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
      case ({imem_resp_val, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // FIFO storage
  always_ff @(posedge clk) begin
    if (imem_resp_val) begin
      pc_buf[wr_ptr]   <= resp_pc;
      inst_buf[wr_ptr] <= imem_resp_data;
    end
  end

endmodule

// File: design/iterative_multiplier.sv
/*
 * Iterative shift-and-add multiplier
 * Low 32 bits of the product after p_num_cycles steps
 */
module iterative_multiplier
  import blimp_pkg::*;
#(
  parameter int p_num_cycles = 16
) (
  input  logic     clk,
  input  logic     reset,
  // From decode
  input  logic     mul_val,
  input  word_t    mul_a,
  input  word_t    mul_b,
  input  addr_t    mul_pc,
  input  reg_idx_t mul_waddr,
  output logic     mul_rdy,
  // To writeback
  output logic     x_val,
  output addr_t    x_pc,
  output reg_idx_t x_waddr,
  output word_t    x_wdata,
  input  logic     x_rdy
);

  // Multiplier bits consumed per step, rounded up
  localparam int p_bits_per_step = (32 + p_num_cycles - 1) / p_num_cycles;

  mul_state_t state;
  logic [5:0] step_cnt;
  logic       advance;
  word_t      a_q;
  word_t      b_q;
  word_t      acc_q;
  word_t      step_a;
  word_t      step_b;
  word_t      step_acc;

  assign mul_rdy = (state == IDLE);
  assign x_val   = (state == DONE);
  assign x_wdata = acc_q;
  // First step happens on the accept edge
  assign advance = (mul_val && mul_rdy) || (state == BUSY);

  always_comb begin
    step_a   = (state == IDLE) ? mul_a : a_q;
    step_b   = (state == IDLE) ? mul_b : b_q;
    step_acc = (state == IDLE) ? '0 : acc_q;
    for (int k = 0; k < p_bits_per_step; k++) begin
      if (step_b[k]) begin
        step_acc = step_acc + (step_a << k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (mul_val) begin
            step_cnt <= 6'd1;
            state    <= (p_num_cycles == 1) ? DONE : BUSY;
          end
        end
        BUSY: begin
          step_cnt <= step_cnt + 6'd1;
          if (step_cnt == 6'(p_num_cycles - 1)) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (x_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      acc_q <= step_acc;
      a_q   <= step_a << p_bits_per_step;
      b_q   <= step_b >> p_bits_per_step;
    end
    if (mul_val && mul_rdy) begin
      x_pc    <= mul_pc;
      x_waddr <= mul_waddr;
    end
  end

endmodule

// File: design/writeback_commit_unit.sv
/*
 * Writeback and commit
 * Picks one pipe result per cycle, multiplier first, and publishes
 * it to the register file and the instruction trace
 */
module writeback_commit_unit
  import blimp_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // ALU result
  input  logic     alu_x_val,
  input  addr_t    alu_x_pc,
  input  reg_idx_t alu_x_waddr,
  input  word_t    alu_x_wdata,
  output logic     alu_x_rdy,
  // Multiplier result
  input  logic     mul_x_val,
  input  addr_t    mul_x_pc,
  input  reg_idx_t mul_x_waddr,
  input  word_t    mul_x_wdata,
  output logic     mul_x_rdy,
  // Register file write
  output logic     cmt_val,
  output reg_idx_t cmt_waddr,
  output word_t    cmt_wdata,
  // Instruction trace
  output logic     trace_val,
  output addr_t    trace_pc,
  output reg_idx_t trace_waddr,
  output word_t    trace_wdata,
  output logic     trace_wen
);

  logic     sel_val;
  addr_t    sel_pc;
  reg_idx_t sel_waddr;
  word_t    sel_wdata;

  // Fixed priority, the multiplier never waits
  assign mul_x_rdy = 1'b1;
  assign alu_x_rdy = !mul_x_val;

  assign sel_val   = mul_x_val || alu_x_val;
  assign sel_pc    = mul_x_val ? mul_x_pc : alu_x_pc;
  assign sel_waddr = mul_x_val ? mul_x_waddr : alu_x_waddr;
  assign sel_wdata = mul_x_val ? mul_x_wdata : alu_x_wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      trace_val <= 1'b0;
      trace_wen <= 1'b0;
    end else begin
      trace_val <= sel_val;
      trace_wen <= sel_val && (sel_waddr != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (sel_val) begin
      trace_pc    <= sel_pc;
      trace_waddr <= sel_waddr;
      trace_wdata <= sel_wdata;
    end
  end

  // Same registered write goes back to decode
  assign cmt_val   = trace_val;
  assign cmt_waddr = trace_waddr;
  assign cmt_wdata = trace_wdata;

endmodule

// File: run.sh
#!/bin/sh
# Build the Blimp core testbench with Verilator and run it
# Exit status of the simulation is the test result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f \
  --top-module blimp_core_tb \
  -o blimp_core_sim

./obj_dir/blimp_core_sim

// File: sim.f
design/blimp_pkg.sv
design/fetch_unit.sv
design/decode_issue_unit.sv
design/alu_unit.sv
design/iterative_multiplier.sv
design/writeback_commit_unit.sv
design/blimp_core.sv
test/blimp_core_assertions.sv
test/blimp_core_tb.sv

// File: test/blimp_core_assertions.sv
/*
 * Protocol checks on the Blimp core ports
 * Quiet outputs in reset and sequential fetch addresses
 */
module blimp_core_assertions
  import blimp_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     imem_req_val,
  input addr_t    imem_req_addr,
  input logic     trace_val
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed checks so far, polled by the testbench
  int fail_count = 0;

  // --------------------
  // Reset
  // --------------------

  // Low through reset and on the first cycle after it
  quiet_in_reset: assert property (
    @(posedge clk) reset |=> (!trace_val && !imem_req_val)
  ) else begin
    fail_count = fail_count + 1;
    $error("trace_val or imem_req_val high during or right after reset");
  end

  // --------------------
  // Fetch port
  // --------------------

  // First fetch address is zero
  first_fetch_addr: assert property (
    @(posedge clk) ($past(reset) && !reset) |-> (imem_req_addr == 32'd0)
  ) else begin
    fail_count = fail_count + 1;
    $error("imem_req_addr not zero after reset");
  end

  // Each request moves on by one word
  fetch_addr_step: assert property (
    @(posedge clk) disable iff (reset)
    imem_req_val |=> (imem_req_addr == $past(imem_req_addr) + 32'd4)
  ) else begin
    fail_count = fail_count + 1;
    $error("imem_req_addr did not step by 4 after a request");
  end

  // No request, no change
  fetch_addr_hold: assert property (
    @(posedge clk) disable iff (reset)
    !imem_req_val |=> $stable(imem_req_addr)
  ) else begin
    fail_count = fail_count + 1;
    $error("imem_req_addr moved without a request");
  end

endmodule

// File: test/blimp_core_tb.sv
/*
 * Blimp core testbench
 * Random RV32 ALU and MUL program, one-cycle instruction memory and
 * an in-order reference model checked against the commit trace
 */
module blimp_core_tb
  import blimp_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    prog_len       = 120;
  localparam int    imem_words     = 256;
  localparam int    timeout_cycles = 5000;
  // ADDI x0, x0, 0
  localparam word_t nop_inst       = 32'h0000_0013;

  logic     clk;
  logic     reset;
  logic     imem_req_val;
  addr_t    imem_req_addr;
  logic     imem_resp_val;
  word_t    imem_resp_data;
  logic     trace_val;
  addr_t    trace_pc;
  reg_idx_t trace_waddr;
  word_t    trace_wdata;
  logic     trace_wen;

  // Memory model
  word_t imem [imem_words];
  logic  req_pending;
  addr_t req_addr;

  // Reference tables, indexed by pc / 4
  reg_idx_t    exp_waddr [prog_len];
  word_t       exp_wdata [prog_len];
  int          prev_writer [prog_len];
  logic        committed [prog_len];
  int          n_commits;
  logic [31:0] rng;

  blimp_core dut (.*);

  bind blimp_core blimp_core_assertions checks (
    .clk           (clk),
    .reset         (reset),
    .imem_req_val  (imem_req_val),
    .imem_req_addr (imem_req_addr),
    .trace_val     (trace_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Op index 0..9 is ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
  function automatic word_t ref_alu(input int op, input word_t a, input word_t b);
    case (op)
      0:       return a + b;
      1:       return a - b;
      2:       return a << b[4:0];
      3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4:       return (a < b) ? 32'd1 : 32'd0;
      5:       return a ^ b;
      6:       return a >> b[4:0];
      7:       return word_t'($signed(a) >>> b[4:0]);
      8:       return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [2:0] op_funct3(input int op);
    case (op)
      0, 1:    return 3'd0;
      2:       return 3'd1;
      3:       return 3'd2;
      4:       return 3'd3;
      5:       return 3'd4;
      6, 7:    return 3'd5;
      8:       return 3'd6;
      default: return 3'd7;
    endcase
  endfunction

  function automatic word_t read_imem(input addr_t addr);
    if (addr < addr_t'(4 * imem_words)) begin
      return imem[addr[9:2]];
    end else begin
      return nop_inst;
    end
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // --------------------
  // Program and model
  // --------------------

  task automatic build_program();
    word_t       regs [32];
    int          last_writer [32];
    logic [31:0] r;
    logic [31:0] r2;
    int          sel;
    int          op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    last_rd;
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       inst;
    logic [2:0]  f3;
    logic [6:0]  f7;
    addr_t       pc;
    for (int k = 0; k < 32; k++) begin
      regs[k]        = '0;
      last_writer[k] = -1;
    end
    last_rd = 5'd1;
    for (int i = 0; i < prog_len; i++) begin
      r   = next_random();
      r2  = next_random();
      pc  = addr_t'(4 * i);
      // Mostly x1..x8, now and then x0
      rd  = (r[7:5] == 3'd0) ? 5'd0 : {2'b00, r[2:0]} + 5'd1;
      // Half the sources come from the latest destination
      rs1 = r[3] ? last_rd : {2'b00, r[11:9]} + 5'd1;
      rs2 = r[13] ? last_rd : {2'b00, r[16:14]} + 5'd1;
      // 0..9 reg ALU, 10..18 imm ALU, 19 LUI, 20 AUIPC, rest MUL
      sel = int'(r[21:17]);
      // Seed x1..x8 first, the register file has no reset
      if (i < 8) begin
        rd  = 5'(i + 1);
        rs1 = 5'd0;
        sel = 10;
      end
      a  = regs[rs1];
      b  = regs[rs2];
      // No SUBI, so immediate ops skip index 1
      op = (sel < 10) ? sel : ((sel == 10) ? 0 : sel - 9);
      f3 = op_funct3(op);
      f7 = (op == 1 || op == 7) ? 7'h20 : 7'h00;
      if (sel < 10) begin
        res  = ref_alu(op, a, b);
        inst = {f7, rs2, rs1, f3, rd, OPC_OP};
      end else if (sel < 19) begin
        if (op == 2 || op == 6 || op == 7) begin
          b    = {27'b0, r2[4:0]};
          inst = {f7, r2[4:0], rs1, f3, rd, OPC_OP_IMM};
        end else begin
          b    = {{20{r2[11]}}, r2[11:0]};
          inst = {r2[11:0], rs1, f3, rd, OPC_OP_IMM};
        end
        res = ref_alu(op, a, b);
      end else if (sel == 19) begin
        res  = {r2[31:12], 12'b0};
        inst = {r2[31:12], rd, OPC_LUI};
      end else if (sel == 20) begin
        res  = pc + {r2[31:12], 12'b0};
        inst = {r2[31:12], rd, OPC_AUIPC};
      end else begin
        // Low half of the product
        res  = a * b;
        inst = {7'h01, rs2, rs1, 3'b000, rd, OPC_OP};
      end
      imem[i]        = inst;
      exp_waddr[i]   = rd;
      exp_wdata[i]   = res;
      prev_writer[i] = (rd == 5'd0) ? -1 : last_writer[rd];
      committed[i]   = 1'b0;
      if (rd != 5'd0) begin
        regs[rd]        = res;
        last_writer[rd] = i;
        last_rd         = rd;
      end
    end
    // Rest of the memory runs NOPs
    for (int i = prog_len; i < imem_words; i++) begin
      imem[i] = nop_inst;
    end
  endtask

  // --------------------
  // Memory model
  // --------------------

  // Answers the request taken on the previous rising edge
  always @(negedge clk) begin
    imem_resp_val  = req_pending;
    imem_resp_data = read_imem(req_addr);
    req_pending    = imem_req_val;
    req_addr       = imem_req_addr;
  end

  // --------------------
  // Trace check
  // --------------------

  task automatic check_commit();
    int idx;
    idx = int'(trace_pc[31:2]);
    if (trace_val && (trace_pc >= addr_t'(4 * prog_len))) begin
      // NOP filler past the program
      assert (trace_waddr == 5'd0)
        else report_failure($sformatf("MISMATCH trace_waddr pc=%h got %h expected %h",
                                      trace_pc, trace_waddr, 5'd0));
      assert (trace_wdata == 32'd0)
        else report_failure($sformatf("MISMATCH trace_wdata pc=%h got %h expected %h",
                                      trace_pc, trace_wdata, 32'd0));
    end else if (trace_val) begin
      assert (!committed[idx])
        else report_failure($sformatf("pc %h committed a second time", trace_pc));
      assert (trace_waddr == exp_waddr[idx])
        else report_failure($sformatf("MISMATCH trace_waddr pc=%h got %h expected %h",
                                      trace_pc, trace_waddr, exp_waddr[idx]));
      assert (trace_wdata == exp_wdata[idx])
        else report_failure($sformatf("MISMATCH trace_wdata pc=%h got %h expected %h",
                                      trace_pc, trace_wdata, exp_wdata[idx]));
      assert (trace_wen == (exp_waddr[idx] != 5'd0))
        else report_failure($sformatf("MISMATCH trace_wen pc=%h got %h expected %h",
                                      trace_pc, trace_wen, exp_waddr[idx] != 5'd0));
      // Earlier write to the same register must be out already
      assert (prev_writer[idx] < 0 || committed[prev_writer[idx]])
        else report_failure($sformatf("write to x%0d at pc %h overtook the one at pc %h",
                                      trace_waddr, trace_pc, 4 * prev_writer[idx]));
      committed[idx] = 1'b1;
      n_commits      = n_commits + 1;
    end else begin
      // Quiet trace never shows a write
      assert (!trace_wen)
        else report_failure($sformatf("MISMATCH trace_wen got %h expected %h",
                                      trace_wen, 1'b0));
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int cycles;
    reset          = 1'b1;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    req_pending    = 1'b0;
    req_addr       = '0;
    n_commits      = 0;
    rng            = 32'h726d_003f;
    build_program();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset  = 1'b0;
    cycles = 0;
    while (n_commits < prog_len && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles = cycles + 1;
      check_commit();
      assert (dut.checks.fail_count == 0)
        else report_failure("a protocol check on the fetch or trace port failed");
    end
    if (n_commits == prog_len) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      report_failure($sformatf("timeout after %0d cycles with %0d of %0d pcs committed",
                               cycles, n_commits, prog_len));
    end
  end

endmodule
